// File: hw/branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module branch_resolve (
    ex_stage_if.sink                    stage,
    input  logic [exu_pkg::xlen_w-1:0]  alu_result,
    output logic [exu_pkg::xlen_w-1:0]  dnpc,
    output logic                        pc_update
);
    import exu_pkg::*;

    logic [xlen_w-1:0] imm_b;
    logic [xlen_w-1:0] snpc;
    logic [xlen_w-1:0] br_target;
    logic              taken;
    logic              is_ctl;

    // b-type offset, bit 0 always zero
    assign imm_b = {{(xlen_w-13){stage.inst[31]}}, stage.inst[31], stage.inst[7],
                    stage.inst[30:25], stage.inst[11:8], 1'b0};

    assign snpc      = stage.pc + inst_step;
    assign br_target = stage.pc + imm_b;

    // **************************************************
    // condition, straight on the operands
    // **************************************************
    always_comb begin
        is_ctl = 1'b1;
        taken  = 1'b0;
        case (stage.op)
            op_beq:  taken = (stage.src_a == stage.src_b);
            op_bne:  taken = (stage.src_a != stage.src_b);
            op_blt:  taken = ($signed(stage.src_a) < $signed(stage.src_b));
            op_bge:  taken = ($signed(stage.src_a) >= $signed(stage.src_b));
            op_bltu: taken = (stage.src_a < stage.src_b);
            op_bgeu: taken = (stage.src_a >= stage.src_b);
            // jumps redirect through dnpc case below
            op_jal, op_jalr: taken = 1'b0;
            default: is_ctl = 1'b0;
        endcase
    end

    // next pc
    always_comb begin
        case (stage.op)
            op_jal:  dnpc = alu_result;
            // jalr clears the low bit of the target
            op_jalr: dnpc = {alu_result[xlen_w-1:1], 1'b0};
            default: dnpc = taken ? br_target : snpc;
        endcase
    end

    // any valid control transfer, taken or not
    assign pc_update = stage.valid && is_ctl;

endmodule

`default_nettype wire

// File: hw/ex_issue_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_issue_reg (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         id_valid,
    input  logic [exu_pkg::xlen_w-1:0]   id_pc,
    input  logic [exu_pkg::inst_w-1:0]   id_inst,
    input  logic [exu_pkg::op_w-1:0]     id_op,
    input  logic [exu_pkg::xlen_w-1:0]   id_src_a,
    input  logic [exu_pkg::xlen_w-1:0]   id_src_b,
    input  logic [exu_pkg::reg_id_w-1:0] id_rd,
    ex_stage_if.source                   stage
);
    import exu_pkg::*;

    // **************************************************
    // slot registers
    // **************************************************
    logic                valid_q;
    logic [xlen_w-1:0]   pc_q;
    logic [inst_w-1:0]   inst_q;
    logic [op_w-1:0]     op_q;
    logic [xlen_w-1:0]   src_a_q;
    logic [xlen_w-1:0]   src_b_q;
    logic [reg_id_w-1:0] rd_q;

    // no stall, new slot every clock
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            pc_q    <= '0;
            inst_q  <= '0;
            op_q    <= op_nop;
            src_a_q <= '0;
            src_b_q <= '0;
            rd_q    <= '0;
        end else begin
            valid_q <= id_valid;
            pc_q    <= id_pc;
            inst_q  <= id_inst;
            op_q    <= id_op;
            src_a_q <= id_src_a;
            src_b_q <= id_src_b;
            rd_q    <= id_rd;
        end
    end

    // every unit reads this one slot
    assign stage.valid = valid_q;
    assign stage.pc    = pc_q;
    assign stage.inst  = inst_q;
    assign stage.op    = op_q;
    assign stage.src_a = src_a_q;
    assign stage.src_b = src_b_q;
    assign stage.rd    = rd_q;

endmodule

`default_nettype wire

// File: hw/ex_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ex_stage_if;
    import exu_pkg::*;

    // one registered execute slot
    logic                valid;
    logic [xlen_w-1:0]   pc;
    logic [inst_w-1:0]   inst;
    logic [op_w-1:0]     op;
    logic [xlen_w-1:0]   src_a;
    logic [xlen_w-1:0]   src_b;
    logic [reg_id_w-1:0] rd;

    // issue register side
    modport source (
        output valid, pc, inst, op, src_a, src_b, rd
    );

    // execute units
    modport sink (
        input valid, pc, inst, op, src_a, src_b, rd
    );

endinterface

`default_nettype wire

// File: hw/exu_pkg.sv
`default_nettype none

package exu_pkg;

    // **************************************************
    // widths
    // **************************************************
    localparam int xlen_w       = 64;
    localparam int word_w       = 32;
    localparam int inst_w       = 32;
    localparam int reg_id_w     = 5;
    localparam int op_w         = 6;
    localparam int shamt_w      = 6;
    localparam int shamt_word_w = 5;
    localparam int cls_w        = 2;
    localparam int alu_fn_w     = 4;

    // sequential step, also the link offset
    localparam logic [xlen_w-1:0] inst_step = xlen_w'(4);

    // **************************************************
    // op codes
    // **************************************************
    localparam logic [op_w-1:0] op_nop   = 6'd0;
    // integer
    localparam logic [op_w-1:0] op_add   = 6'd1;
    localparam logic [op_w-1:0] op_sub   = 6'd2;
    localparam logic [op_w-1:0] op_sll   = 6'd3;
    localparam logic [op_w-1:0] op_slt   = 6'd4;
    localparam logic [op_w-1:0] op_sltu  = 6'd5;
    localparam logic [op_w-1:0] op_xor   = 6'd6;
    localparam logic [op_w-1:0] op_srl   = 6'd7;
    localparam logic [op_w-1:0] op_sra   = 6'd8;
    localparam logic [op_w-1:0] op_or    = 6'd9;
    localparam logic [op_w-1:0] op_and   = 6'd10;
    // word forms
    localparam logic [op_w-1:0] op_addw  = 6'd11;
    localparam logic [op_w-1:0] op_subw  = 6'd12;
    localparam logic [op_w-1:0] op_sllw  = 6'd13;
    localparam logic [op_w-1:0] op_srlw  = 6'd14;
    localparam logic [op_w-1:0] op_sraw  = 6'd15;
    // upper immediate
    localparam logic [op_w-1:0] op_lui   = 6'd16;
    localparam logic [op_w-1:0] op_auipc = 6'd17;
    // jumps and branches
    localparam logic [op_w-1:0] op_jal   = 6'd18;
    localparam logic [op_w-1:0] op_jalr  = 6'd19;
    localparam logic [op_w-1:0] op_beq   = 6'd20;
    localparam logic [op_w-1:0] op_bne   = 6'd21;
    localparam logic [op_w-1:0] op_blt   = 6'd22;
    localparam logic [op_w-1:0] op_bge   = 6'd23;
    localparam logic [op_w-1:0] op_bltu  = 6'd24;
    localparam logic [op_w-1:0] op_bgeu  = 6'd25;
    // multiply / divide
    localparam logic [op_w-1:0] op_mul   = 6'd26;
    localparam logic [op_w-1:0] op_mulw  = 6'd27;
    localparam logic [op_w-1:0] op_div   = 6'd28;
    localparam logic [op_w-1:0] op_divu  = 6'd29;
    localparam logic [op_w-1:0] op_remu  = 6'd30;
    localparam logic [op_w-1:0] op_divw  = 6'd31;
    localparam logic [op_w-1:0] op_divuw = 6'd32;
    localparam logic [op_w-1:0] op_remw  = 6'd33;
    localparam logic [op_w-1:0] op_remuw = 6'd34;

    // write-back classes
    localparam logic [cls_w-1:0] cls_none = 2'd0;
    localparam logic [cls_w-1:0] cls_alu  = 2'd1;
    localparam logic [cls_w-1:0] cls_md   = 2'd2;
    localparam logic [cls_w-1:0] cls_link = 2'd3;

    // alu functions
    localparam logic [alu_fn_w-1:0] fn_add  = 4'd0;
    localparam logic [alu_fn_w-1:0] fn_sub  = 4'd1;
    localparam logic [alu_fn_w-1:0] fn_sll  = 4'd2;
    localparam logic [alu_fn_w-1:0] fn_slt  = 4'd3;
    localparam logic [alu_fn_w-1:0] fn_sltu = 4'd4;
    localparam logic [alu_fn_w-1:0] fn_xor  = 4'd5;
    localparam logic [alu_fn_w-1:0] fn_srl  = 4'd6;
    localparam logic [alu_fn_w-1:0] fn_sra  = 4'd7;
    localparam logic [alu_fn_w-1:0] fn_or   = 4'd8;
    localparam logic [alu_fn_w-1:0] fn_and  = 4'd9;
    localparam logic [alu_fn_w-1:0] fn_pass = 4'd10;

    // most negative dividends, for signed overflow
    localparam logic [xlen_w-1:0] xlen_min = {1'b1, {(xlen_w-1){1'b0}}};
    localparam logic [word_w-1:0] word_min = {1'b1, {(word_w-1){1'b0}}};

endpackage

`default_nettype wire

// File: hw/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top (
    input  logic                         clk,
    input  logic                         rst,
    // decoded slot from id
    input  logic                         id_valid,
    input  logic [exu_pkg::xlen_w-1:0]   id_pc,
    input  logic [exu_pkg::inst_w-1:0]   id_inst,
    input  logic [exu_pkg::op_w-1:0]     id_op,
    input  logic [exu_pkg::xlen_w-1:0]   id_src_a,
    input  logic [exu_pkg::xlen_w-1:0]   id_src_b,
    input  logic [exu_pkg::reg_id_w-1:0] id_rd,
    // toward write-back
    output logic                         wb_valid,
    output logic [exu_pkg::xlen_w-1:0]   wb_pc,
    output logic [exu_pkg::inst_w-1:0]   wb_inst,
    // register file write
    output logic                         reg_wr_wen,
    output logic [exu_pkg::reg_id_w-1:0] reg_wr_id,
    output logic [exu_pkg::xlen_w-1:0]   reg_wr_value,
    // fetch redirect
    output logic [exu_pkg::xlen_w-1:0]   dnpc,
    output logic                         pc_update
);
    import exu_pkg::*;

    logic [xlen_w-1:0] alu_result;
    logic [xlen_w-1:0] md_result;

    ex_stage_if stage_bus ();

    // **************************************************
    // stage register and units
    // **************************************************
    ex_issue_reg ex_issue_reg_inst (
        .clk      (clk),
        .rst      (rst),
        .id_valid (id_valid),
        .id_pc    (id_pc),
        .id_inst  (id_inst),
        .id_op    (id_op),
        .id_src_a (id_src_a),
        .id_src_b (id_src_b),
        .id_rd    (id_rd),
        .stage    (stage_bus.source)
    );

    int_alu int_alu_inst (
        .stage      (stage_bus.sink),
        .alu_result (alu_result)
    );

    mul_div_unit mul_div_unit_inst (
        .stage     (stage_bus.sink),
        .md_result (md_result)
    );

    writeback_mux writeback_mux_inst (
        .stage        (stage_bus.sink),
        .alu_result   (alu_result),
        .md_result    (md_result),
        .reg_wr_wen   (reg_wr_wen),
        .reg_wr_id    (reg_wr_id),
        .reg_wr_value (reg_wr_value)
    );

    branch_resolve branch_resolve_inst (
        .stage      (stage_bus.sink),
        .alu_result (alu_result),
        .dnpc       (dnpc),
        .pc_update  (pc_update)
    );

    // pass-through toward wb, not masked by valid
    assign wb_valid = stage_bus.valid;
    assign wb_pc    = stage_bus.pc;
    assign wb_inst  = stage_bus.inst;

endmodule

`default_nettype wire

// File: hw/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu (
    ex_stage_if.sink                    stage,
    output logic [exu_pkg::xlen_w-1:0]  alu_result
);
    import exu_pkg::*;

    logic [alu_fn_w-1:0]     fn;
    logic                    word_op;
    logic [shamt_w-1:0]      sh;
    logic [shamt_word_w-1:0] sh_w;
    logic [word_w-1:0]       a_w;
    logic [word_w-1:0]       b_w;
    logic [xlen_w-1:0]       full_res;
    logic [word_w-1:0]       word_res;

    assign sh   = stage.src_b[shamt_w-1:0];
    assign sh_w = stage.src_b[shamt_word_w-1:0];
    assign a_w  = stage.src_a[word_w-1:0];
    assign b_w  = stage.src_b[word_w-1:0];

    // **************************************************
    // op to function
    // **************************************************
    always_comb begin
        fn      = fn_add;
        word_op = 1'b0;
        case (stage.op)
            // auipc, jal, jalr all add src_a + src_b
            op_add, op_addw, op_auipc, op_jal, op_jalr: fn = fn_add;
            op_sub, op_subw: fn = fn_sub;
            op_sll, op_sllw: fn = fn_sll;
            op_slt:          fn = fn_slt;
            op_sltu:         fn = fn_sltu;
            op_xor:          fn = fn_xor;
            op_srl, op_srlw: fn = fn_srl;
            op_sra, op_sraw: fn = fn_sra;
            op_or:           fn = fn_or;
            op_and:          fn = fn_and;
            // lui immediate arrives in src_a
            op_lui:          fn = fn_pass;
            default:         fn = fn_add;
        endcase
        case (stage.op)
            op_addw, op_subw, op_sllw, op_srlw, op_sraw: word_op = 1'b1;
            default: word_op = 1'b0;
        endcase
    end

    // full width path
    always_comb begin
        case (fn)
            fn_sub:  full_res = stage.src_a - stage.src_b;
            fn_sll:  full_res = stage.src_a << sh;
            fn_slt:  full_res = {{(xlen_w-1){1'b0}},
                                 $signed(stage.src_a) < $signed(stage.src_b)};
            fn_sltu: full_res = {{(xlen_w-1){1'b0}}, stage.src_a < stage.src_b};
            fn_xor:  full_res = stage.src_a ^ stage.src_b;
            fn_srl:  full_res = stage.src_a >> sh;
            fn_sra:  full_res = $signed(stage.src_a) >>> sh;
            fn_or:   full_res = stage.src_a | stage.src_b;
            fn_and:  full_res = stage.src_a & stage.src_b;
            fn_pass: full_res = stage.src_a;
            default: full_res = stage.src_a + stage.src_b;
        endcase
    end

    // word path, low 32 bits only, 5-bit shamt
    always_comb begin
        case (fn)
            fn_add:  word_res = a_w + b_w;
            fn_sub:  word_res = a_w - b_w;
            fn_sll:  word_res = a_w << sh_w;
            fn_srl:  word_res = a_w >> sh_w;
            fn_sra:  word_res = $signed(a_w) >>> sh_w;
            default: word_res = full_res[word_w-1:0];
        endcase
    end

    // word results sign-extended from bit 31
    assign alu_result = word_op ? {{(xlen_w-word_w){word_res[word_w-1]}}, word_res}
                                : full_res;

endmodule

`default_nettype wire

// File: hw/mul_div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_div_unit (
    ex_stage_if.sink                    stage,
    output logic [exu_pkg::xlen_w-1:0]  md_result
);
    import exu_pkg::*;

    logic [xlen_w-1:0] a, b;
    logic [word_w-1:0] a_w, b_w;
    logic              div_zero, div_ovf, divw_zero, divw_ovf;
    logic [xlen_w-1:0] prod, quo_s, quo_u, rem_u;
    logic [word_w-1:0] prod_w, quo_sw, quo_uw, rem_sw, rem_uw;
    logic [xlen_w-1:0] full_res;
    logic [word_w-1:0] word_res;
    logic              word_op;

    assign a   = stage.src_a;
    assign b   = stage.src_b;
    assign a_w = a[word_w-1:0];
    assign b_w = b[word_w-1:0];

    // **************************************************
    // raw arithmetic
    // **************************************************
    assign prod   = a * b;
    assign quo_s  = $signed(a) / $signed(b);
    assign quo_u  = a / b;
    assign rem_u  = a % b;
    assign prod_w = a_w * b_w;
    assign quo_sw = $signed(a_w) / $signed(b_w);
    assign quo_uw = a_w / b_w;
    assign rem_sw = $signed(a_w) % $signed(b_w);
    assign rem_uw = a_w % b_w;

    // corner detection, min / -1 overflows
    assign div_zero  = (b == '0);
    assign div_ovf   = (a == xlen_min) && (b == '1);
    assign divw_zero = (b_w == '0);
    assign divw_ovf  = (a_w == word_min) && (b_w == '1);

    // select, corners replace raw result
    always_comb begin
        full_res = '0;
        word_res = '0;
        word_op  = 1'b0;
        case (stage.op)
            op_mul:  full_res = prod;
            op_div:  full_res = div_zero ? '1 : (div_ovf ? a : quo_s);
            op_divu: full_res = div_zero ? '1 : quo_u;
            op_remu: full_res = div_zero ? a : rem_u;
            op_mulw: begin
                word_op  = 1'b1;
                word_res = prod_w;
            end
            op_divw: begin
                word_op  = 1'b1;
                word_res = divw_zero ? '1 : (divw_ovf ? a_w : quo_sw);
            end
            op_divuw: begin
                word_op  = 1'b1;
                word_res = divw_zero ? '1 : quo_uw;
            end
            op_remw: begin
                word_op  = 1'b1;
                word_res = divw_zero ? a_w : (divw_ovf ? '0 : rem_sw);
            end
            op_remuw: begin
                word_op  = 1'b1;
                word_res = divw_zero ? a_w : rem_uw;
            end
            default: full_res = '0;
        endcase
    end

    assign md_result = word_op ? {{(xlen_w-word_w){word_res[word_w-1]}}, word_res}
                               : full_res;

endmodule

`default_nettype wire

// File: hw/writeback_mux.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_mux (
    ex_stage_if.sink                      stage,
    input  logic [exu_pkg::xlen_w-1:0]    alu_result,
    input  logic [exu_pkg::xlen_w-1:0]    md_result,
    output logic                          reg_wr_wen,
    output logic [exu_pkg::reg_id_w-1:0]  reg_wr_id,
    output logic [exu_pkg::xlen_w-1:0]    reg_wr_value
);
    import exu_pkg::*;

    logic [cls_w-1:0]  op_cls;
    logic [xlen_w-1:0] wr_value;

    // **************************************************
    // op classification
    // **************************************************
    always_comb begin
        case (stage.op)
            op_add, op_sub, op_sll, op_slt, op_sltu,
            op_xor, op_srl, op_sra, op_or, op_and:
                op_cls = cls_alu;
            op_addw, op_subw, op_sllw, op_srlw, op_sraw:
                op_cls = cls_alu;
            op_lui, op_auipc:
                op_cls = cls_alu;
            op_mul, op_mulw, op_div, op_divu, op_remu,
            op_divw, op_divuw, op_remw, op_remuw:
                op_cls = cls_md;
            // link value for jumps
            op_jal, op_jalr:
                op_cls = cls_link;
            // branches and bubbles write nothing
            op_nop, op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu:
                op_cls = cls_none;
            default:
                op_cls = cls_none;
        endcase
    end

    // result source
    always_comb begin
        case (op_cls)
            cls_alu:  wr_value = alu_result;
            cls_md:   wr_value = md_result;
            cls_link: wr_value = stage.pc + inst_step;
            default:  wr_value = '0;
        endcase
    end

    // empty slot drives all zeros
    assign reg_wr_wen   = stage.valid && (op_cls != cls_none);
    assign reg_wr_id    = stage.valid ? stage.rd : '0;
    assign reg_wr_value = stage.valid ? wr_value : '0;

endmodule

`default_nettype wire

// File: project.f
hw/exu_pkg.sv
hw/ex_stage_if.sv
hw/ex_issue_reg.sv
hw/int_alu.sv
hw/mul_div_unit.sv
hw/writeback_mux.sv
hw/branch_resolve.sv
hw/exu_top.sv
testbench/exu_tb_chk.sv
testbench/exu_tb.sv

// File: testbench/exu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exu_tb;
    import exu_pkg::*;

    localparam int          num_items  = 400;
    localparam int          wait_limit = 20;
    // taps 32, 22, 2, 1
    localparam logic [31:0] lfsr_taps  = 32'h8020_0003;

    logic                clk;
    logic                rst;
    logic                id_valid;
    logic [xlen_w-1:0]   id_pc;
    logic [inst_w-1:0]   id_inst;
    logic [op_w-1:0]     id_op;
    logic [xlen_w-1:0]   id_src_a;
    logic [xlen_w-1:0]   id_src_b;
    logic [reg_id_w-1:0] id_rd;
    logic                wb_valid;
    logic [xlen_w-1:0]   wb_pc;
    logic [inst_w-1:0]   wb_inst;
    logic                reg_wr_wen;
    logic [reg_id_w-1:0] reg_wr_id;
    logic [xlen_w-1:0]   reg_wr_value;
    logic [xlen_w-1:0]   dnpc;
    logic                pc_update;

    logic [31:0]         lfsr_state;
    logic [op_w-1:0]     op_table [0:33];
    // slot numbering shared by driver and compare
    int                  sent     = 0;
    int                  done_tag = -1;

    exu_top exu_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // **************************************************
    // random source
    // **************************************************
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [63:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[62:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic logic [63:0] sext_word(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    // **************************************************
    // reference model
    // **************************************************
    function automatic void expected_result(
        input  logic [op_w-1:0]   op,
        input  logic [xlen_w-1:0] pc,
        input  logic [inst_w-1:0] inst,
        input  logic [xlen_w-1:0] a,
        input  logic [xlen_w-1:0] b,
        output logic              wen,
        output logic [xlen_w-1:0] value,
        output logic [xlen_w-1:0] npc,
        output logic              upd
    );
        logic [31:0] aw;
        logic [31:0] bw;
        logic [31:0] w;
        logic [63:0] off;
        logic        taken;
        logic        zero_w;
        logic        ovf_w;
        aw     = a[31:0];
        bw     = b[31:0];
        zero_w = (bw == 32'd0);
        ovf_w  = (aw == 32'h8000_0000) && (bw == 32'hffff_ffff);
        // b-type immediate
        off    = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        wen    = 1'b1;
        upd    = 1'b0;
        taken  = 1'b0;
        value  = '0;
        npc    = pc + 64'd4;
        case (op)
            op_add:   value = a + b;
            op_sub:   value = a - b;
            op_sll:   value = a << b[5:0];
            op_slt:   value = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            op_sltu:  value = (a < b) ? 64'd1 : 64'd0;
            op_xor:   value = a ^ b;
            op_srl:   value = a >> b[5:0];
            op_sra:   value = $signed(a) >>> b[5:0];
            op_or:    value = a | b;
            op_and:   value = a & b;
            op_addw:  value = sext_word(aw + bw);
            op_subw:  value = sext_word(aw - bw);
            op_sllw:  value = sext_word(aw << b[4:0]);
            op_srlw:  value = sext_word(aw >> b[4:0]);
            op_sraw: begin
                w     = $signed(aw) >>> b[4:0];
                value = sext_word(w);
            end
            op_lui:   value = a;
            op_auipc: value = a + b;
            // link is the next sequential pc
            op_jal: begin
                value = pc + 64'd4;
                npc   = a + b;
                upd   = 1'b1;
            end
            op_jalr: begin
                value = pc + 64'd4;
                npc   = (a + b) & ~64'd1;
                upd   = 1'b1;
            end
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
                wen = 1'b0;
                upd = 1'b1;
                case (op)
                    op_beq:  taken = (a == b);
                    op_bne:  taken = (a != b);
                    op_blt:  taken = ($signed(a) < $signed(b));
                    op_bge:  taken = ($signed(a) >= $signed(b));
                    op_bltu: taken = (a < b);
                    default: taken = (a >= b);
                endcase
            end
            op_mul:   value = a * b;
            op_mulw:  value = sext_word(aw * bw);
            // divide by zero gives all ones
            // min over -1 gives the dividend
            op_div: begin
                if (b == 64'd0)
                    value = '1;
                else if (a == 64'h8000_0000_0000_0000 && b == '1)
                    value = a;
                else
                    value = $signed(a) / $signed(b);
            end
            op_divu:  value = (b == 64'd0) ? '1 : a / b;
            op_remu:  value = (b == 64'd0) ? a : a % b;
            op_divw: begin
                if (zero_w)
                    value = '1;
                else if (ovf_w)
                    value = sext_word(aw);
                else begin
                    w     = $signed(aw) / $signed(bw);
                    value = sext_word(w);
                end
            end
            op_divuw: value = zero_w ? '1 : sext_word(aw / bw);
            op_remw: begin
                if (zero_w)
                    value = sext_word(aw);
                else if (ovf_w)
                    value = '0;
                else begin
                    w     = $signed(aw) % $signed(bw);
                    value = sext_word(w);
                end
            end
            op_remuw: value = zero_w ? sext_word(aw) : sext_word(aw % bw);
            default:  wen = 1'b0;
        endcase
        if (taken)
            npc = pc + off;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at time %0t: signal %s got %h expected %h", $time, name, got, exp);
            $display("Errors found");
            $fatal(1, "output mismatch");
        end
    endtask

    // **************************************************
    // stimulus
    // **************************************************
    task automatic make_item();
        logic [63:0] r;
        take_bits(6, r);
        id_op = op_table[r % 34];
        // about one slot in eight left empty
        take_bits(3, r);
        id_valid = (r[2:0] != 3'd0);
        take_bits(62, r);
        id_pc = {r[61:0], 2'b00};
        take_bits(32, r);
        id_inst = r[31:0];
        take_bits(5, r);
        id_rd = r[4:0];
        take_bits(64, r);
        id_src_a = r;
        take_bits(64, r);
        id_src_b = r;
        // forced zero divisor, overflow and equal operands
        take_bits(3, r);
        case (r[2:0])
            3'd0: id_src_b = '0;
            3'd1: begin
                if (id_op == op_divw || id_op == op_remw)
                    id_src_a[31:0] = 32'h8000_0000;
                else
                    id_src_a = xlen_min;
                id_src_b = '1;
            end
            3'd2: id_src_b = id_src_a;
            default: ;
        endcase
    endtask

    initial begin : drive_proc
        int wait_cnt;
        op_table = '{op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl,
                     op_sra, op_or, op_and, op_addw, op_subw, op_sllw, op_srlw,
                     op_sraw, op_lui, op_auipc, op_jal, op_jalr, op_beq, op_bne,
                     op_blt, op_bge, op_bltu, op_bgeu, op_mul, op_mulw, op_div,
                     op_divu, op_remu, op_divw, op_divuw, op_remw, op_remuw};
        lfsr_state = 32'd8;
        rst        = 1'b1;
        id_valid   = 1'b0;
        id_pc      = '0;
        id_inst    = '0;
        id_op      = op_nop;
        id_src_a   = '0;
        id_src_b   = '0;
        id_rd      = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // empty slots right after reset
        repeat (3) @(negedge clk);
        for (int n = 0; n < num_items; n++) begin
            make_item();
            sent++;
            @(negedge clk);
        end
        // drain until the last slot is compared
        wait_cnt = 0;
        while (done_tag != sent && wait_cnt < wait_limit) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (done_tag != sent) begin
            $display("compare process stopped, last slot never checked");
            $display("Errors found");
            $fatal(1, "timeout");
        end else if (exu_top_inst.exu_tb_chk_inst.fail_count != 0) begin
            $display("protocol assertions failed");
            $display("Errors found");
            $fatal(1, "assertion failure");
        end else begin
            $display("No errors");
            $finish;
        end
    end

    // **************************************************
    // capture at rise and compare at fall
    // **************************************************
    initial begin : compare_proc
        logic                s_valid;
        logic [xlen_w-1:0]   s_pc;
        logic [inst_w-1:0]   s_inst;
        logic [op_w-1:0]     s_op;
        logic [xlen_w-1:0]   s_a;
        logic [xlen_w-1:0]   s_b;
        logic [reg_id_w-1:0] s_rd;
        int                  s_tag;
        logic                e_wen;
        logic [xlen_w-1:0]   e_value;
        logic [xlen_w-1:0]   e_npc;
        logic                e_upd;
        forever begin
            @(posedge clk);
            // reset loads an empty nop slot
            s_valid = rst ? 1'b0 : id_valid;
            s_pc    = rst ? '0 : id_pc;
            s_inst  = rst ? '0 : id_inst;
            s_op    = rst ? op_nop : id_op;
            s_a     = rst ? '0 : id_src_a;
            s_b     = rst ? '0 : id_src_b;
            s_rd    = rst ? '0 : id_rd;
            s_tag   = sent;
            @(negedge clk);
            expected_result(s_op, s_pc, s_inst, s_a, s_b, e_wen, e_value, e_npc, e_upd);
            check_value("wb_valid", wb_valid, s_valid);
            check_value("wb_pc", wb_pc, s_pc);
            check_value("wb_inst", wb_inst, s_inst);
            check_value("reg_wr_wen", reg_wr_wen, s_valid & e_wen);
            check_value("reg_wr_id", reg_wr_id, s_valid ? s_rd : '0);
            check_value("reg_wr_value", reg_wr_value, s_valid ? e_value : '0);
            check_value("dnpc", dnpc, e_npc);
            check_value("pc_update", pc_update, s_valid & e_upd);
            // protocol assertions fired at the last rising edge
            if (exu_top_inst.exu_tb_chk_inst.fail_count != 0) begin
                $display("a protocol assertion in the bound checker failed");
                $display("Errors found");
                $fatal(1, "assertion failure");
            end
            done_tag = s_tag;
        end
    end

endmodule

`default_nettype wire

// File: testbench/exu_tb_chk.sv
`timescale 1ns/1ps
`default_nettype none

module exu_tb_chk (
    input logic clk,
    input logic rst,
    input logic id_valid,
    input logic wb_valid,
    input logic reg_wr_wen,
    input logic pc_update
);
    // failures so far, polled by the testbench every cycle
    int fail_count = 0;

    // **************************************************
    // stage protocol
    // **************************************************
    // a write only from a live slot
    wen_in_slot: assert property (@(posedge clk) disable iff (rst)
        reg_wr_wen |-> wb_valid)
    else begin
        fail_count++;
        $error("reg_wr_wen high while wb_valid low");
    end

    // redirect only from a live slot
    update_in_slot: assert property (@(posedge clk) disable iff (rst)
        pc_update |-> wb_valid)
    else begin
        fail_count++;
        $error("pc_update high while wb_valid low");
    end

    // one cycle latency once the first cycle after reset has passed
    valid_follows_id: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (wb_valid == $past(id_valid)))
    else begin
        fail_count++;
        $error("wb_valid does not match id_valid of the previous cycle");
    end

endmodule

bind exu_top exu_tb_chk exu_tb_chk_inst (
    .clk        (clk),
    .rst        (rst),
    .id_valid   (id_valid),
    .wb_valid   (wb_valid),
    .reg_wr_wen (reg_wr_wen),
    .pc_update  (pc_update)
);

`default_nettype wire
